/* filelist.f */
rtl/rv_isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/exec_if.sv
rtl/instr_sequencer.sv
rtl/exec_sequencer.sv
rtl/cpu_controller.sv
verification/cpu_controller_chk.sv
verification/cpu_controller_tb.sv

/* rtl/cpu_controller.sv */
`timescale 1ns/100ps
`default_nettype none

// Multicycle RV32I control unit
module cpu_controller #(
    parameter int OPCODE_W = 7
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      go,
    input  wire [OPCODE_W-1:0]       opcode,
    input  wire rv_isa_pkg::funct3_t func3,
    input  wire                      comparator,
    output wire                      ir_en,
    output wire                      pc_en,
    output wire ctrl_pkg::pc_sel_t   pc_sel,
    output wire                      alu_src,
    output wire                      reg_write,
    output wire ctrl_pkg::wb_sel_t   wb_sel,
    output wire                      is_byte,
    output wire                      is_half,
    output wire                      is_word,
    output wire                      mem_read,
    output wire                      mem_write,
    output wire                      instr_done
);

    exec_if exec_bus ();

    instr_sequencer #(
        .OPCODE_W (OPCODE_W)
    ) instr_seq_i (
        .clk    (clk),
        .reset  (reset),
        .go     (go),
        .opcode (opcode),
        .func3  (func3),
        .ir_en  (ir_en),
        .bus    (exec_bus.issue)
    );

    exec_sequencer exec_seq_i (
        .clk        (clk),
        .reset      (reset),
        .comparator (comparator),
        .bus        (exec_bus.execute),
        .pc_en      (pc_en),
        .pc_sel     (pc_sel),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .wb_sel     (wb_sel),
        .is_byte    (is_byte),
        .is_half    (is_half),
        .is_word    (is_word),
        .mem_read   (mem_read),
        .mem_write  (mem_write)
    );

    assign instr_done = exec_bus.done;    // Already a flop in exec_sequencer

endmodule

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // Operation class handed from decode to execute
    typedef enum logic [2:0] {
        ALU_REG,
        ALU_IMM,    // Also LUI and AUIPC
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        ILLEGAL     // Steps the PC and nothing else
    } op_class_e;

    // Next PC source
    typedef logic [1:0] pc_sel_t;

    localparam pc_sel_t PC_SEQ    = 2'd0;
    localparam pc_sel_t PC_BRANCH = 2'd1;
    localparam pc_sel_t PC_JAL    = 2'd2;
    localparam pc_sel_t PC_JALR   = 2'd3;

    // Register file write data source
    typedef logic [1:0] wb_sel_t;

    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_MEM  = 2'd1;
    localparam wb_sel_t WB_LINK = 2'd2;    // PC + 4

    // Memory access width
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

endpackage

`default_nettype wire

/* rtl/exec_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Start/done exchange between decode and execute
interface exec_if;

    logic                start;       // One cycle, only while execute is idle
    ctrl_pkg::op_class_e op_class;    // Valid with start
    ctrl_pkg::mem_size_e mem_size;    // Valid with start
    logic                done;        // One cycle, one per start

    modport issue (
        output start,
        output op_class,
        output mem_size,
        input  done
    );

    modport execute (
        input  start,
        input  op_class,
        input  mem_size,
        output done
    );

endinterface

`default_nettype wire

/* rtl/exec_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_sequencer (
    input  wire                clk,
    input  wire                reset,
    input  wire                comparator,
    exec_if.execute            bus,
    output logic               pc_en,
    output ctrl_pkg::pc_sel_t  pc_sel,
    output logic               alu_src,
    output logic               reg_write,
    output ctrl_pkg::wb_sel_t  wb_sel,
    output logic               is_byte,
    output logic               is_half,
    output logic               is_word,
    output logic               mem_read,
    output logic               mem_write
);

    typedef enum logic [2:0] {
        IDLE,
        PC_STEP,    // PC + 4, selects set up
        STEP1,
        STEP2,      // Load write-back only
        FINISH      // done, selects cleared
    } state_e;

    state_e              state;
    state_e              state_next;
    ctrl_pkg::op_class_e cls;    // Class of the running instruction

    // ALU operand B is the immediate
    function automatic logic alu_src_for(ctrl_pkg::op_class_e c);
        logic imm;
        case (c)
            ctrl_pkg::ALU_IMM,
            ctrl_pkg::LOAD,
            ctrl_pkg::STORE,
            ctrl_pkg::JALR:
                imm = 1'b1;
            default:
                imm = 1'b0;
        endcase
        return imm;
    endfunction

    function automatic ctrl_pkg::wb_sel_t wb_sel_for(ctrl_pkg::op_class_e c);
        ctrl_pkg::wb_sel_t src;
        case (c)
            ctrl_pkg::LOAD:
                src = ctrl_pkg::WB_MEM;
            ctrl_pkg::JAL,
            ctrl_pkg::JALR:
                src = ctrl_pkg::WB_LINK;
            default:
                src = ctrl_pkg::WB_ALU;
        endcase
        return src;
    endfunction

    // One-hot {byte, half, word}, zero for non-memory classes
    function automatic logic [2:0] size_for(ctrl_pkg::op_class_e c, ctrl_pkg::mem_size_e s);
        logic [2:0] lines;
        lines = 3'b000;
        if (c == ctrl_pkg::LOAD || c == ctrl_pkg::STORE)
        begin
            case (s)
                ctrl_pkg::SIZE_BYTE: lines = 3'b100;
                ctrl_pkg::SIZE_HALF: lines = 3'b010;
                ctrl_pkg::SIZE_WORD: lines = 3'b001;
                default:             lines = 3'b000;
            endcase
        end
        return lines;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Step sequence
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (state)
            IDLE:    state_next = bus.start ? PC_STEP : IDLE;
            PC_STEP: state_next = (cls == ctrl_pkg::ILLEGAL) ? FINISH : STEP1;
            STEP1:   state_next = (cls == ctrl_pkg::LOAD) ? STEP2 : FINISH;
            STEP2:   state_next = FINISH;
            default: state_next = IDLE;    // FINISH included
        endcase
    end

    // Class is captured once per instruction
    always_ff @(posedge clk)
    begin
        if (state == IDLE && bus.start)
            cls <= bus.op_class;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered strobes, decoded from the state being entered
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= IDLE;
            pc_en     <= 1'b0;
            pc_sel    <= ctrl_pkg::PC_SEQ;
            alu_src   <= 1'b0;
            reg_write <= 1'b0;
            wb_sel    <= ctrl_pkg::WB_ALU;
            is_byte   <= 1'b0;
            is_half   <= 1'b0;
            is_word   <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            bus.done  <= 1'b0;
        end
        else
        begin
            state <= state_next;

            // Strobes last one cycle; pc_sel only leaves PC_SEQ with pc_en
            pc_en     <= 1'b0;
            pc_sel    <= ctrl_pkg::PC_SEQ;
            reg_write <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            bus.done  <= 1'b0;

            case (state_next)
                PC_STEP:
                begin
                    pc_en   <= 1'b1;
                    alu_src <= alu_src_for(bus.op_class);
                    wb_sel  <= wb_sel_for(bus.op_class);
                    {is_byte, is_half, is_word} <= size_for(bus.op_class, bus.mem_size);
                end
                STEP1:
                begin
                    case (cls)
                        ctrl_pkg::ALU_REG,
                        ctrl_pkg::ALU_IMM:
                            reg_write <= 1'b1;
                        ctrl_pkg::LOAD:
                            mem_read  <= 1'b1;
                        ctrl_pkg::STORE:
                            mem_write <= 1'b1;
                        ctrl_pkg::BRANCH:
                        begin
                            // comparator taken at the edge that enters step 1
                            if (comparator)
                            begin
                                pc_en  <= 1'b1;
                                pc_sel <= ctrl_pkg::PC_BRANCH;
                            end
                        end
                        ctrl_pkg::JAL:
                        begin
                            reg_write <= 1'b1;
                            pc_en     <= 1'b1;
                            pc_sel    <= ctrl_pkg::PC_JAL;
                        end
                        ctrl_pkg::JALR:
                        begin
                            reg_write <= 1'b1;
                            pc_en     <= 1'b1;
                            pc_sel    <= ctrl_pkg::PC_JALR;
                        end
                        default:
                        begin
                        end
                    endcase
                end
                STEP2:
                    reg_write <= 1'b1;    // Load data to rd
                FINISH:
                begin
                    bus.done <= 1'b1;
                    alu_src  <= 1'b0;
                    wb_sel   <= ctrl_pkg::WB_ALU;
                    {is_byte, is_half, is_word} <= 3'b000;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/instr_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_sequencer #(
    parameter int OPCODE_W = 7
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      go,
    input  wire [OPCODE_W-1:0]       opcode,
    input  wire rv_isa_pkg::funct3_t func3,
    output logic                     ir_en,
    exec_if.issue                    bus
);

    // Opcode and constants are widened to a common compare width
    localparam int CMP_W = (OPCODE_W > rv_isa_pkg::OPCODE_BITS) ?
                           OPCODE_W : rv_isa_pkg::OPCODE_BITS;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,        // Checks go, launches ir_en
        DECODE,       // IR loads this cycle, start goes out next
        WAIT_EXEC
    } state_e;

    state_e              state;
    logic [CMP_W-1:0]    op_ext;
    logic                size_ok;     // func3 names a load width
    logic                store_ok;    // Stores take only the signed codes
    ctrl_pkg::op_class_e cls_dec;
    ctrl_pkg::mem_size_e size_dec;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch / issue FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= IDLE;
            ir_en     <= 1'b0;
            bus.start <= 1'b0;
        end
        else
        begin
            ir_en     <= 1'b0;
            bus.start <= 1'b0;
            case (state)
                IDLE:
                    if (go)
                        state <= FETCH;
                FETCH:
                begin
                    // Go low between instructions parks the sequencer
                    if (go)
                    begin
                        ir_en <= 1'b1;
                        state <= DECODE;
                    end
                    else
                        state <= IDLE;
                end
                DECODE:
                begin
                    bus.start <= 1'b1;    // Execute samples the decode with this pulse
                    state     <= WAIT_EXEC;
                end
                WAIT_EXEC:
                    if (bus.done)
                        state <= FETCH;
                default:
                    state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode of the IR fields
    ////////////////////////////////////////////////////////////////////////////

    assign op_ext = CMP_W'(opcode);

    always_comb
    begin
        size_dec = ctrl_pkg::SIZE_WORD;
        size_ok  = 1'b1;
        case (func3)
            rv_isa_pkg::F3_BYTE,
            rv_isa_pkg::F3_BYTE_U:
                size_dec = ctrl_pkg::SIZE_BYTE;
            rv_isa_pkg::F3_HALF,
            rv_isa_pkg::F3_HALF_U:
                size_dec = ctrl_pkg::SIZE_HALF;
            rv_isa_pkg::F3_WORD:
                size_dec = ctrl_pkg::SIZE_WORD;
            default:
                size_ok = 1'b0;
        endcase
    end

    assign store_ok = (func3 == rv_isa_pkg::F3_BYTE) ||
                      (func3 == rv_isa_pkg::F3_HALF) ||
                      (func3 == rv_isa_pkg::F3_WORD);

    // Unknown opcodes fall through to ILLEGAL
    always_comb
    begin
        cls_dec = ctrl_pkg::ILLEGAL;
        case (op_ext)
            CMP_W'(rv_isa_pkg::OP_RTYPE):
                cls_dec = ctrl_pkg::ALU_REG;
            CMP_W'(rv_isa_pkg::OP_ITYPE),
            CMP_W'(rv_isa_pkg::OP_LUI),
            CMP_W'(rv_isa_pkg::OP_AUIPC):
                cls_dec = ctrl_pkg::ALU_IMM;
            CMP_W'(rv_isa_pkg::OP_LOAD):
                if (size_ok)
                    cls_dec = ctrl_pkg::LOAD;
            CMP_W'(rv_isa_pkg::OP_STORE):
                if (store_ok)
                    cls_dec = ctrl_pkg::STORE;
            CMP_W'(rv_isa_pkg::OP_BRANCH):
                cls_dec = ctrl_pkg::BRANCH;
            CMP_W'(rv_isa_pkg::OP_JAL):
                cls_dec = ctrl_pkg::JAL;
            CMP_W'(rv_isa_pkg::OP_JALR):
                cls_dec = ctrl_pkg::JALR;
            default:
                cls_dec = ctrl_pkg::ILLEGAL;
        endcase
    end

    assign bus.op_class = cls_dec;
    assign bus.mem_size = size_dec;

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Field widths of the base encoding
    localparam int OPCODE_BITS = 7;
    localparam int FUNCT3_BITS = 3;

    typedef logic [OPCODE_BITS-1:0] opcode_t;
    typedef logic [FUNCT3_BITS-1:0] funct3_t;

    // Major opcodes the controller knows about
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // Access width codes of loads and stores
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;    // LBU
    localparam funct3_t F3_HALF_U = 3'b101;    // LHU

endpackage

`default_nettype wire

/* verification/cpu_controller_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_controller_chk (
    input wire                    clk,
    input wire                    reset,
    input wire                    ir_en,
    input wire                    pc_en,
    input wire ctrl_pkg::pc_sel_t pc_sel,
    input wire                    reg_write,
    input wire                    is_byte,
    input wire                    is_half,
    input wire                    is_word,
    input wire                    mem_read,
    input wire                    mem_write,
    input wire                    instr_done
);

    int unsigned fail_count = 0;    // Assertion failures so far
    logic        pc_step;
    logic        in_exec;           // After the PC step, up to instr_done

    // Only the PC step raises pc_en with the sequential source
    assign pc_step = pc_en && (pc_sel == ctrl_pkg::PC_SEQ);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            in_exec <= 1'b0;
        else if (instr_done)
            in_exec <= 1'b0;
        else if (pc_step)
            in_exec <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output exclusivity
    ////////////////////////////////////////////////////////////////////////////

    mem_excl: assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
        else
        begin
            $error("mem_read and mem_write high in the same cycle");
            fail_count++;
        end

    size_onehot: assert property (@(posedge clk) disable iff (reset)
                                  $onehot0({is_byte, is_half, is_word}))
        else
        begin
            $error("more than one size line high");
            fail_count++;
        end

    write_excl: assert property (@(posedge clk) disable iff (reset) !(reg_write && mem_write))
        else
        begin
            $error("reg_write and mem_write high in the same cycle");
            fail_count++;
        end

    // No new fetch while an instruction is executing
    no_fetch: assert property (@(posedge clk) disable iff (reset) (in_exec || pc_step) |-> !ir_en)
        else
        begin
            $error("ir_en raised between the PC step and instr_done");
            fail_count++;
        end

endmodule

bind cpu_controller cpu_controller_chk chk_i (
    .clk        (clk),
    .reset      (reset),
    .ir_en      (ir_en),
    .pc_en      (pc_en),
    .pc_sel     (pc_sel),
    .reg_write  (reg_write),
    .is_byte    (is_byte),
    .is_half    (is_half),
    .is_word    (is_word),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .instr_done (instr_done)
);

`default_nettype wire

/* verification/cpu_controller_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_controller_tb;

    localparam int OPCODE_W       = 7;
    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 100;    // Longest instruction plus go gap

    logic                  clk;
    logic                  reset;
    logic                  go;
    logic [OPCODE_W-1:0]   opcode;
    rv_isa_pkg::funct3_t   func3;
    logic                  comparator;
    logic                  ir_en;
    logic                  pc_en;
    ctrl_pkg::pc_sel_t     pc_sel;
    logic                  alu_src;
    logic                  reg_write;
    ctrl_pkg::wb_sel_t     wb_sel;
    logic                  is_byte;
    logic                  is_half;
    logic                  is_word;
    logic                  mem_read;
    logic                  mem_write;
    logic                  instr_done;

    logic [31:0] rng_state = 32'hd88;
    int          cycles = 0;
    int          instr_idx;
    int          gap;

    cpu_controller #(
        .OPCODE_W (OPCODE_W)
    ) cpu_controller_i (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .opcode     (opcode),
        .func3      (func3),
        .comparator (comparator),
        .ir_en      (ir_en),
        .pc_en      (pc_en),
        .pc_sel     (pc_sel),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .wb_sel     (wb_sel),
        .is_byte    (is_byte),
        .is_half    (is_half),
        .is_word    (is_word),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .instr_done (instr_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end
        else if (cpu_controller_i.chk_i.fail_count != 0)
        begin
            $display("A bound assertion on the DUT outputs failed (instruction %0d)", instr_idx);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // About a quarter of the picks are raw random codes
    function automatic logic [6:0] pick_opcode(input logic [31:0] r);
        logic [6:0] op;
        case (r[3:0])
            4'd0:        op = rv_isa_pkg::OP_RTYPE;
            4'd1:        op = rv_isa_pkg::OP_ITYPE;
            4'd2:        op = rv_isa_pkg::OP_LUI;
            4'd3:        op = rv_isa_pkg::OP_AUIPC;
            4'd4, 4'd5:  op = rv_isa_pkg::OP_LOAD;
            4'd6, 4'd7:  op = rv_isa_pkg::OP_STORE;
            4'd8, 4'd9:  op = rv_isa_pkg::OP_BRANCH;
            4'd10:       op = rv_isa_pkg::OP_JAL;
            4'd11:       op = rv_isa_pkg::OP_JALR;
            default:     op = r[10:4];
        endcase
        return op;
    endfunction

    function automatic ctrl_pkg::op_class_e classify(input logic [6:0] op, input logic [2:0] f3);
        ctrl_pkg::op_class_e c;
        c = ctrl_pkg::ILLEGAL;
        if (op == rv_isa_pkg::OP_RTYPE)
            c = ctrl_pkg::ALU_REG;
        else if (op inside {rv_isa_pkg::OP_ITYPE, rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC})
            c = ctrl_pkg::ALU_IMM;
        else if (op == rv_isa_pkg::OP_LOAD && f3 inside {rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_HALF,
                 rv_isa_pkg::F3_WORD, rv_isa_pkg::F3_BYTE_U, rv_isa_pkg::F3_HALF_U})
            c = ctrl_pkg::LOAD;
        else if (op == rv_isa_pkg::OP_STORE &&
                 f3 inside {rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_HALF, rv_isa_pkg::F3_WORD})
            c = ctrl_pkg::STORE;
        else if (op == rv_isa_pkg::OP_BRANCH)
            c = ctrl_pkg::BRANCH;
        else if (op == rv_isa_pkg::OP_JAL)
            c = ctrl_pkg::JAL;
        else if (op == rv_isa_pkg::OP_JALR)
            c = ctrl_pkg::JALR;
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h (instruction %0d)",
                     name, got, exp, instr_idx);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic expect_outputs(input logic e_ir, input logic e_pc_en, input logic [1:0] e_pc_sel,
                                  input logic e_alu_src, input logic e_reg_write,
                                  input logic [1:0] e_wb_sel, input logic [2:0] e_size,
                                  input logic e_mem_read, input logic e_mem_write,
                                  input logic e_done);
        compare_value("ir_en", ir_en, e_ir);
        compare_value("pc_en", pc_en, e_pc_en);
        compare_value("pc_sel", pc_sel, e_pc_sel);
        compare_value("alu_src", alu_src, e_alu_src);
        compare_value("reg_write", reg_write, e_reg_write);
        compare_value("wb_sel", wb_sel, e_wb_sel);
        compare_value("is_byte", is_byte, e_size[2]);
        compare_value("is_half", is_half, e_size[1]);
        compare_value("is_word", is_word, e_size[0]);
        compare_value("mem_read", mem_read, e_mem_read);
        compare_value("mem_write", mem_write, e_mem_write);
        compare_value("instr_done", instr_done, e_done);
    endtask

    // One class step, selects held from the PC step
    task automatic expect_step(input ctrl_pkg::op_class_e cls, input int step, input logic cmp,
                               input logic a_src, input logic [1:0] wb, input logic [2:0] size);
        logic       pe;
        logic [1:0] ps;
        logic       rw;
        logic       mr;
        logic       mw;
        pe = 1'b0;
        ps = ctrl_pkg::PC_SEQ;
        rw = 1'b0;
        mr = 1'b0;
        mw = 1'b0;
        case (cls)
            ctrl_pkg::ALU_REG,
            ctrl_pkg::ALU_IMM:
                rw = 1'b1;
            ctrl_pkg::LOAD:
                if (step == 1)
                    mr = 1'b1;
                else
                    rw = 1'b1;    // Write-back of the loaded data
            ctrl_pkg::STORE:
                mw = 1'b1;
            ctrl_pkg::BRANCH:
                if (cmp)
                begin
                    pe = 1'b1;
                    ps = ctrl_pkg::PC_BRANCH;
                end
            ctrl_pkg::JAL:
            begin
                rw = 1'b1;
                pe = 1'b1;
                ps = ctrl_pkg::PC_JAL;
            end
            ctrl_pkg::JALR:
            begin
                rw = 1'b1;
                pe = 1'b1;
                ps = ctrl_pkg::PC_JALR;
            end
            default: ;
        endcase
        expect_outputs(1'b0, pe, ps, a_src, rw, wb, size, mr, mw, 1'b0);
    endtask

    // Waits for ir_en after instr_done or after idle; gap is the number of go-low cycles
    task automatic await_fetch(input int gap_len);
        int wait_cycles;
        int expected;
        // Go back high one cycle after instr_done keeps ir_en two cycles after instr_done
        expected = (gap_len == 1) ? 1 : 2;
        repeat (gap_len)
        begin
            @(negedge clk);
            expect_outputs(1'b0, 1'b0, 2'd0, 1'b0, 1'b0, 2'd0, 3'b000, 1'b0, 1'b0, 1'b0);
        end
        go          = 1'b1;
        wait_cycles = 0;
        do
        begin
            @(negedge clk);
            wait_cycles++;
            if (!ir_en)
                expect_outputs(1'b0, 1'b0, 2'd0, 1'b0, 1'b0, 2'd0, 3'b000, 1'b0, 1'b0, 1'b0);
        end
        while (!ir_en && wait_cycles < 8);
        if (!ir_en)
        begin
            $display("No ir_en within 8 cycles of go being high (instruction %0d)", instr_idx);
            $display("TEST FAILED");
            $fatal(1);
        end
        compare_value("ir_en delay", wait_cycles, expected);
    endtask

    // Entered at the falling edge of the ir_en cycle N
    task automatic execute_instruction(output int next_gap);
        logic [31:0]         r;
        logic [6:0]          op;
        logic [2:0]          f3;
        logic                cmp;
        ctrl_pkg::op_class_e cls;
        logic                a_src;
        logic [1:0]          wb;
        logic [2:0]          size;
        int                  steps;
        int                  s;

        expect_outputs(1'b1, 1'b0, 2'd0, 1'b0, 1'b0, 2'd0, 3'b000, 1'b0, 1'b0, 1'b0);
        r          = xorshift32();
        op         = pick_opcode(r);
        f3         = r[14:12];
        cmp        = r[20];
        opcode     = op;       // Held like an instruction register
        func3      = f3;
        comparator = cmp;
        go         = r[24];    // Ignored until instr_done
        cls        = classify(op, f3);

        a_src = cls inside {ctrl_pkg::ALU_IMM, ctrl_pkg::LOAD, ctrl_pkg::STORE, ctrl_pkg::JALR};
        if (cls == ctrl_pkg::LOAD)
            wb = ctrl_pkg::WB_MEM;
        else if (cls inside {ctrl_pkg::JAL, ctrl_pkg::JALR})
            wb = ctrl_pkg::WB_LINK;
        else
            wb = ctrl_pkg::WB_ALU;
        size = 3'b000;
        if (cls == ctrl_pkg::LOAD || cls == ctrl_pkg::STORE)
            size = (f3[1:0] == 2'b00) ? 3'b100 : (f3[1:0] == 2'b01) ? 3'b010 : 3'b001;
        steps = (cls == ctrl_pkg::LOAD) ? 2 : (cls == ctrl_pkg::ILLEGAL) ? 0 : 1;

        @(negedge clk);    // N+1, decode and start
        expect_outputs(1'b0, 1'b0, 2'd0, 1'b0, 1'b0, 2'd0, 3'b000, 1'b0, 1'b0, 1'b0);
        r  = xorshift32();
        go = r[0];
        @(negedge clk);    // N+2, PC step
        expect_outputs(1'b0, 1'b1, ctrl_pkg::PC_SEQ, a_src, 1'b0, wb, size, 1'b0, 1'b0, 1'b0);
        r  = xorshift32();
        go = r[0];
        for (s = 1; s <= steps; s++)
        begin
            @(negedge clk);
            expect_step(cls, s, cmp, a_src, wb, size);
            r  = xorshift32();
            go = r[0];
        end
        @(negedge clk);    // N+3+S, selects back to zero
        expect_outputs(1'b0, 1'b0, 2'd0, 1'b0, 1'b0, 2'd0, 3'b000, 1'b0, 1'b0, 1'b1);

        r        = xorshift32();
        next_gap = (r[1:0] == 2'b00) ? int'(r[3:2]) + 1 : 0;
        go       = (next_gap == 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        reset      = 1'b1;
        go         = 1'b0;
        opcode     = '0;
        func3      = '0;
        comparator = 1'b0;
        instr_idx  = 0;
        gap        = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        await_fetch(3);    // Idle after reset, then go rises
        for (instr_idx = 0; instr_idx < NUM_INSTR; instr_idx++)
        begin
            execute_instruction(gap);
            if (instr_idx < NUM_INSTR - 1)
                await_fetch(gap);
        end
        go = 1'b0;
        repeat (4) @(negedge clk);

        if (cpu_controller_i.chk_i.fail_count != 0)
        begin
            $display("%0d assertion failures", cpu_controller_i.chk_i.fail_count);
            $display("TEST FAILED");
            $fatal(1);
        end
        else
        begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
